// File: board_pkg.sv
package board_pkg;

	localparam int NUM_SQUARES = 64;
	localparam int RANK_LEN = 8; // Squares per rank

	// Bit 0 of a position is the first square of the bottom rank,
	// so the top rank is the last RANK_LEN bits

	typedef enum logic [2:0] {
		MOVE_NONE    = 3'd0, // Rejected or idle
		MOVE_QUIET   = 3'd1,
		MOVE_CAPTURE = 3'd2,
		UNDO_QUIET   = 3'd3,
		UNDO_CAPTURE = 3'd4
	} move_kind_e;

endpackage

// File: board_updater.sv
module board_updater #(
	parameter int NUM_SQUARES = board_pkg::NUM_SQUARES,
	parameter int RANK_LEN    = board_pkg::RANK_LEN
) (
	input  logic                                           clk,
	input  logic                                           arst_n,
	input  logic                                           enable,
	input  logic                                           color_type, // 1 white, 0 black
	input  logic                                           undo,
	input  logic [NUM_SQUARES-1:0]                         initial_position,
	input  logic [NUM_SQUARES-1:0]                         moved_position,
	input  logic [piece_pkg::KIND_W-1:0]                   moving_piece,
	input  logic [piece_pkg::KIND_W-1:0]                   captured_piece,
	output logic [NUM_SQUARES-1:0]                         square_en,
	output logic [NUM_SQUARES-1:0][piece_pkg::CODE_W-1:0] square_code
);

	logic                         s1_valid;
	logic [NUM_SQUARES-1:0]       s1_origin;
	logic [NUM_SQUARES-1:0]       s1_dest;
	logic [piece_pkg::CODE_W-1:0] s1_origin_code;
	logic [piece_pkg::CODE_W-1:0] s1_dest_code;

	move_classifier #(
		.NUM_SQUARES (NUM_SQUARES),
		.RANK_LEN    (RANK_LEN)
	) u_classifier (
		.clk              (clk),
		.arst_n           (arst_n),
		.enable           (enable),
		.color_type       (color_type),
		.undo             (undo),
		.initial_position (initial_position),
		.moved_position   (moved_position),
		.moving_piece     (moving_piece),
		.captured_piece   (captured_piece),
		.s1_valid         (s1_valid),
		.s1_origin        (s1_origin),
		.s1_dest          (s1_dest),
		.s1_origin_code   (s1_origin_code),
		.s1_dest_code     (s1_dest_code)
	);

	square_writer #(
		.NUM_SQUARES (NUM_SQUARES)
	) u_writer (
		.clk            (clk),
		.arst_n         (arst_n),
		.s1_valid       (s1_valid),
		.s1_origin      (s1_origin),
		.s1_dest        (s1_dest),
		.s1_origin_code (s1_origin_code),
		.s1_dest_code   (s1_dest_code),
		.square_en      (square_en),
		.square_code    (square_code)
	);

endmodule

// File: board_updater_properties.sv
module board_updater_properties #(
	parameter int NUM_SQUARES = board_pkg::NUM_SQUARES
) (
	input logic                                           clk,
	input logic                                           arst_n,
	input logic [NUM_SQUARES-1:0]                         square_en,
	input logic [NUM_SQUARES-1:0][piece_pkg::CODE_W-1:0] square_code
);

	int assert_errors = 0;

	// A move touches an origin and a destination only
	a_two_squares: assert property (@(posedge clk) disable iff (!arst_n)
		$countones(square_en) <= 2)
		else begin
			assert_errors++;
			$error("More than two squares enabled: %h", square_en);
		end

	for (genvar i = 0; i < NUM_SQUARES; i++) begin : g_square
		a_masked_empty: assert property (@(posedge clk) disable iff (!arst_n)
			!square_en[i] |-> square_code[i] == '0)
			else begin
				assert_errors++;
				$error("Square %0d has a code without its enable", i);
			end
	end

	a_reset_zero: assert property (@(posedge clk)
		!arst_n |-> (square_en == '0 && square_code == '0))
		else begin
			assert_errors++;
			$error("Outputs not cleared during reset");
		end

endmodule

bind board_updater board_updater_properties #(
	.NUM_SQUARES (NUM_SQUARES)
) u_props (
	.clk         (clk),
	.arst_n      (arst_n),
	.square_en   (square_en),
	.square_code (square_code)
);

// File: move_classifier.sv
module move_classifier #(
	parameter int NUM_SQUARES = board_pkg::NUM_SQUARES,
	parameter int RANK_LEN    = board_pkg::RANK_LEN
) (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         enable,
	input  logic                         color_type,
	input  logic                         undo,
	input  logic [NUM_SQUARES-1:0]       initial_position,
	input  logic [NUM_SQUARES-1:0]       moved_position,
	input  logic [piece_pkg::KIND_W-1:0] moving_piece,
	input  logic [piece_pkg::KIND_W-1:0] captured_piece,
	output logic                         s1_valid,
	output logic [NUM_SQUARES-1:0]       s1_origin,
	output logic [NUM_SQUARES-1:0]       s1_dest,
	output logic [piece_pkg::CODE_W-1:0] s1_origin_code,
	output logic [piece_pkg::CODE_W-1:0] s1_dest_code
);

	logic [piece_pkg::CODE_W-1:0] mover_code;
	logic [piece_pkg::CODE_W-1:0] captured_code;
	logic [piece_pkg::CODE_W-1:0] queen_code;
	logic [piece_pkg::CODE_W-1:0] origin_code;
	logic [piece_pkg::CODE_W-1:0] dest_code;
	logic                         mover_valid;
	logic                         captured_valid;
	logic                         move_ok;
	logic                         far_rank;
	logic                         promote;
	board_pkg::move_kind_e        move_kind;

	piece_encoder u_mover_enc (
		.kind  (moving_piece),
		.color (color_type),
		.code  (mover_code),
		.valid (mover_valid)
	);

	piece_encoder u_captured_enc (
		.kind  (captured_piece),
		.color (~color_type), // Captured piece is the other side
		.code  (captured_code),
		.valid (captured_valid)
	);

	assign move_ok = enable && $onehot(initial_position) && $onehot(moved_position) &&
		(initial_position != moved_position) && mover_valid && (|moving_piece) &&
		captured_valid;

	always_comb begin
		if (!move_ok)
			move_kind = board_pkg::MOVE_NONE;
		else if (undo)
			move_kind = (|captured_piece) ? board_pkg::UNDO_CAPTURE : board_pkg::UNDO_QUIET;
		else
			move_kind = (|captured_piece) ? board_pkg::MOVE_CAPTURE : board_pkg::MOVE_QUIET;
	end

	// Far rank depends on the side to move
	always_comb begin
		far_rank = 1'b0;
		case (color_type)
			piece_pkg::COLOR_WHITE: far_rank = |moved_position[NUM_SQUARES-1 -: RANK_LEN];
			piece_pkg::COLOR_BLACK: far_rank = |moved_position[RANK_LEN-1:0];
		endcase
	end

	assign promote = (moving_piece == piece_pkg::KIND_PAWN) && far_rank &&
		(move_kind == board_pkg::MOVE_QUIET || move_kind == board_pkg::MOVE_CAPTURE);
	assign queen_code = {color_type, piece_pkg::CODE_QUEEN};

	always_comb begin
		origin_code = piece_pkg::EMPTY_CODE;
		dest_code   = piece_pkg::EMPTY_CODE;
		case (move_kind)
			board_pkg::MOVE_QUIET, board_pkg::MOVE_CAPTURE:
				dest_code = promote ? queen_code : mover_code;
			board_pkg::UNDO_QUIET:
				origin_code = mover_code;
			board_pkg::UNDO_CAPTURE: begin
				origin_code = mover_code;
				dest_code   = captured_code; // Put the taken piece back
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			s1_valid <= 1'b0;
		else
			s1_valid <= (move_kind != board_pkg::MOVE_NONE);
	end

	always_ff @(posedge clk) begin
		s1_origin      <= initial_position;
		s1_dest        <= moved_position;
		s1_origin_code <= origin_code;
		s1_dest_code   <= dest_code;
	end

endmodule

// File: piece_encoder.sv
module piece_encoder (
	input  logic [piece_pkg::KIND_W-1:0] kind,
	input  logic                         color,
	output logic [piece_pkg::CODE_W-1:0] code,
	output logic                         valid
);

	always_comb begin
		valid = 1'b1;
		case (kind)
			piece_pkg::KIND_PAWN:
				code = {color, piece_pkg::CODE_PAWN};
			piece_pkg::KIND_ROOK:
				code = {color, piece_pkg::CODE_ROOK};
			piece_pkg::KIND_KNIGHT:
				code = {color, piece_pkg::CODE_KNIGHT};
			piece_pkg::KIND_BISHOP:
				code = {color, piece_pkg::CODE_BISHOP};
			piece_pkg::KIND_QUEEN:
				code = {color, piece_pkg::CODE_QUEEN};
			piece_pkg::KIND_KING:
				code = {color, piece_pkg::CODE_KING};
			'0:
				code = piece_pkg::EMPTY_CODE; // No piece
			default: begin
				code  = piece_pkg::EMPTY_CODE; // Multi-hot kind
				valid = 1'b0;
			end
		endcase
	end

endmodule

// File: piece_pkg.sv
package piece_pkg;

	localparam int KIND_W = 6; // One-hot kind inputs
	localparam int CODE_W = 6; // Color bit plus kind code
	localparam int KIND_CODE_W = CODE_W - 1;

	// One-hot piece kind as presented on the move inputs
	typedef enum logic [KIND_W-1:0] {
		KIND_PAWN   = 6'b000001,
		KIND_ROOK   = 6'b000010,
		KIND_KNIGHT = 6'b000100,
		KIND_BISHOP = 6'b001000,
		KIND_QUEEN  = 6'b010000,
		KIND_KING   = 6'b100000
	} piece_kind_e;

	// Kind field of a square code
	typedef enum logic [KIND_CODE_W-1:0] {
		CODE_KNIGHT = 5'b00001,
		CODE_PAWN   = 5'b00010,
		CODE_KING   = 5'b00100,
		CODE_BISHOP = 5'b01000,
		CODE_ROOK   = 5'b10000,
		CODE_QUEEN  = 5'b11000
	} kind_code_e;

	localparam logic [CODE_W-1:0] EMPTY_CODE = '0;

	// Color bit sits above the kind code
	localparam logic COLOR_WHITE = 1'b1;
	localparam logic COLOR_BLACK = 1'b0;

endpackage

// File: square_writer.sv
module square_writer #(
	parameter int NUM_SQUARES = board_pkg::NUM_SQUARES
) (
	input  logic                                           clk,
	input  logic                                           arst_n,
	input  logic                                           s1_valid,
	input  logic [NUM_SQUARES-1:0]                         s1_origin,
	input  logic [NUM_SQUARES-1:0]                         s1_dest,
	input  logic [piece_pkg::CODE_W-1:0]                   s1_origin_code,
	input  logic [piece_pkg::CODE_W-1:0]                   s1_dest_code,
	output logic [NUM_SQUARES-1:0]                         square_en,
	output logic [NUM_SQUARES-1:0][piece_pkg::CODE_W-1:0] square_code
);

	logic [NUM_SQUARES-1:0]                         next_en;
	logic [NUM_SQUARES-1:0][piece_pkg::CODE_W-1:0] next_code;

	// Payload from stage 1 is only trusted with s1_valid
	assign next_en = s1_valid ? (s1_origin | s1_dest) : '0;

	for (genvar i = 0; i < NUM_SQUARES; i++) begin : g_square
		always_comb begin
			if (s1_valid && s1_origin[i])
				next_code[i] = s1_origin_code;
			else if (s1_valid && s1_dest[i])
				next_code[i] = s1_dest_code;
			else
				next_code[i] = piece_pkg::EMPTY_CODE; // Untouched square
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			square_en   <= '0;
			square_code <= '0;
		end else begin
			square_en   <= next_en;
			square_code <= next_code;
		end
	end

endmodule

// File: src.f
piece_pkg.sv
board_pkg.sv
piece_encoder.sv
move_classifier.sv
square_writer.sv
board_updater.sv
board_updater_properties.sv
tb_board_updater.sv

// File: tb_board_updater.sv
module tb_board_updater;

	localparam int NUM_DIRECTED = 16;
	localparam int NUM_RANDOM = 400;
	localparam int MAX_CYCLES = NUM_DIRECTED + NUM_RANDOM + 50;
	localparam int DRIVE_DLY = 10;
	localparam logic [5:0] PAWN = 6'b000001;

	logic clk;
	logic arst_n;
	logic enable;
	logic color_type;
	logic undo;
	logic [63:0] initial_position;
	logic [63:0] moved_position;
	logic [5:0] moving_piece;
	logic [5:0] captured_piece;
	logic [63:0] square_en;
	logic [63:0][5:0] square_code;

	logic [63:0] exp_en_q[$];
	logic [63:0][5:0] exp_code_q[$];
	int cycle_count;

	board_updater dut (
		.clk              (clk),
		.arst_n           (arst_n),
		.enable           (enable),
		.color_type       (color_type),
		.undo             (undo),
		.initial_position (initial_position),
		.moved_position   (moved_position),
		.moving_piece     (moving_piece),
		.captured_piece   (captured_piece),
		.square_en        (square_en),
		.square_code      (square_code)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("CHECKS FAILED");
			$fatal(1, "Timeout: run did not finish within %0d cycles", MAX_CYCLES);
		end
	end

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	function automatic logic [4:0] kind_code(input logic [5:0] kind);
		case (kind)
			6'b000001: return 5'b00010; // Pawn
			6'b000010: return 5'b10000; // Rook
			6'b000100: return 5'b00001; // Knight
			6'b001000: return 5'b01000; // Bishop
			6'b010000: return 5'b11000; // Queen
			6'b100000: return 5'b00100; // King
			default:   return 5'b00000;
		endcase
	endfunction

	function automatic void model_move(input logic en, input logic col, input logic und,
		input logic [63:0] from_sq, input logic [63:0] to_sq, input logic [5:0] mover,
		input logic [5:0] taken, output logic [63:0] exp_en, output logic [63:0][5:0] exp_code);
		logic ok;
		logic promote;
		logic [5:0] mover_code;
		logic [5:0] taken_code;
		logic [5:0] orig_code;
		logic [5:0] dest_code;
		ok = en && $onehot(from_sq) && $onehot(to_sq) && (from_sq != to_sq) &&
			$onehot(mover) && (taken == 6'd0 || $onehot(taken));
		exp_en = '0;
		exp_code = '0;
		if (ok) begin
			mover_code = {col, kind_code(mover)};
			taken_code = (taken == 6'd0) ? 6'd0 : {~col, kind_code(taken)};
			promote = (mover == PAWN) && (col ? |to_sq[63:56] : |to_sq[7:0]);
			if (und) begin
				orig_code = mover_code;
				dest_code = taken_code;
			end else begin
				orig_code = 6'd0;
				dest_code = promote ? {col, 5'b11000} : mover_code; // Queen on far rank
			end
			exp_en = from_sq | to_sq;
			for (int i = 0; i < 64; i++) begin
				if (from_sq[i])
					exp_code[i] = orig_code;
				if (to_sq[i])
					exp_code[i] = dest_code;
			end
		end
	endfunction

	// Checks the move from two cycles back, then drives the next one
	task automatic apply_move(input logic en, input logic col, input logic und,
		input logic [63:0] from_sq, input logic [63:0] to_sq, input logic [5:0] mover,
		input logic [5:0] taken);
		logic [63:0] exp_en;
		logic [63:0][5:0] exp_code;
		@(posedge clk);
		#DRIVE_DLY;
		exp_en = exp_en_q.pop_front();
		exp_code = exp_code_q.pop_front();
		check_value("square_en", square_en, exp_en);
		for (int i = 0; i < 64; i++)
			check_value($sformatf("square_code[%0d]", i), square_code[i], exp_code[i]);
		enable = en;
		color_type = col;
		undo = und;
		initial_position = from_sq;
		moved_position = to_sq;
		moving_piece = mover;
		captured_piece = taken;
		model_move(en, col, und, from_sq, to_sq, mover, taken, exp_en, exp_code);
		exp_en_q.push_back(exp_en);
		exp_code_q.push_back(exp_code);
	endtask

	task automatic random_move();
		int r;
		int from_i;
		int to_i;
		logic col;
		logic [63:0] from_sq;
		logic [63:0] to_sq;
		logic [5:0] mover;
		logic [5:0] taken;
		col = $urandom_range(0, 1);
		from_i = $urandom_range(0, 63);
		to_i = (from_i + 1 + $urandom_range(0, 62)) % 64;
		mover = 6'b1 << $urandom_range(0, 5);
		r = $urandom_range(0, 99);
		if (r < 20) begin // Pawn step onto the far rank
			mover = PAWN;
			to_i = col ? $urandom_range(56, 63) : $urandom_range(0, 7);
			from_i = col ? to_i - 8 : to_i + 8;
		end
		from_sq = 64'd1 << from_i;
		to_sq = 64'd1 << to_i;
		r = $urandom_range(0, 99);
		if (r < 6)
			to_sq = from_sq;
		else if (r < 12)
			from_sq = from_sq | (64'd1 << $urandom_range(0, 63));
		else if (r < 18)
			mover = $urandom_range(0, 63);
		r = $urandom_range(0, 99);
		if (r < 40)
			taken = 6'd0;
		else if (r < 92)
			taken = 6'b1 << $urandom_range(0, 5);
		else
			taken = $urandom_range(0, 63);
		apply_move($urandom_range(0, 9) != 0, col, $urandom_range(0, 1), from_sq, to_sq,
			mover, taken);
	endtask

	function automatic logic [63:0] sq(input int idx);
		return 64'd1 << idx;
	endfunction

	initial begin
		void'($urandom(32'h0b4b8558));
		clk = 1'b0;
		arst_n = 1'b0;
		enable = 1'b0;
		color_type = 1'b0;
		undo = 1'b0;
		initial_position = '0;
		moved_position = '0;
		moving_piece = '0;
		captured_piece = '0;
		cycle_count = 0;
		repeat (8) begin
			@(posedge clk);
			#DRIVE_DLY;
			check_value("square_en", square_en, 64'd0);
			for (int i = 0; i < 64; i++)
				check_value($sformatf("square_code[%0d]", i), square_code[i], 64'd0);
		end
		arst_n = 1'b1;
		repeat (2) begin // Pipeline still holds idle cycles
			exp_en_q.push_back('0);
			exp_code_q.push_back('0);
		end

		apply_move(1'b0, 1'b1, 1'b0, sq(1), sq(18), 6'b000100, 6'd0);
		apply_move(1'b1, 1'b1, 1'b0, sq(1), sq(18), 6'b000100, 6'd0);
		apply_move(1'b1, 1'b0, 1'b0, sq(61), sq(34), 6'b001000, 6'b000100);
		apply_move(1'b1, 1'b1, 1'b0, sq(52), sq(60), PAWN, 6'd0);
		apply_move(1'b1, 1'b1, 1'b0, sq(54), sq(63), PAWN, 6'b000010);
		apply_move(1'b1, 1'b0, 1'b0, sq(9), sq(1), PAWN, 6'd0);
		apply_move(1'b1, 1'b0, 1'b0, sq(14), sq(7), PAWN, 6'b001000);
		apply_move(1'b1, 1'b1, 1'b0, sq(12), sq(20), PAWN, 6'd0);
		apply_move(1'b1, 1'b1, 1'b1, sq(8), sq(0), 6'b000010, 6'd0);
		apply_move(1'b1, 1'b0, 1'b1, sq(40), sq(20), 6'b010000, PAWN);
		apply_move(1'b1, 1'b1, 1'b0, sq(3) | sq(4), sq(11), 6'b100000, 6'd0);
		apply_move(1'b1, 1'b1, 1'b0, sq(27), sq(27), 6'b000010, 6'd0);
		apply_move(1'b1, 1'b0, 1'b0, sq(27), sq(35), 6'b000110, 6'd0);
		apply_move(1'b1, 1'b0, 1'b0, sq(27), sq(35), 6'd0, 6'd0);
		apply_move(1'b1, 1'b1, 1'b1, sq(27), sq(35), 6'b000010, 6'b101000);
		apply_move(1'b0, 1'b0, 1'b0, '0, '0, 6'd0, 6'd0);

		repeat (NUM_RANDOM)
			random_move();
		repeat (2)
			apply_move(1'b0, 1'b0, 1'b0, '0, '0, 6'd0, 6'd0);

		check_value("assertion failures", dut.u_props.assert_errors, 64'd0);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule
